//--- common/ni_pkg.sv
package ni_pkg;

	//////////////////////////////////////////////////////////////
	// field widths
	//////////////////////////////////////////////////////////////

	localparam int FLIT_PAYLOAD_W = 10; // payload bits per flit, tail not counted
	localparam int ROUTE_W        = 10; // route field of a header flit
	localparam int CODE_W         = 8;  // code part of a core word
	localparam int DATA_W         = 24; // data part of a core word
	localparam int WORD_W         = CODE_W + DATA_W; // full core word, 32

	localparam int FLITS_PER_WORD = 3; // data flits needed for one core word
	localparam int CARRIED_W      = FLITS_PER_WORD * FLIT_PAYLOAD_W; // 30 bits on the link
	localparam int PAD_W          = WORD_W - CARRIED_W; // code msbs that never travel

	//////////////////////////////////////////////////////////////
	// link flit formats
	//
	//   header:  [ tail | route   ]
	//   data:    [ tail | payload ]
	//
	// tail sits at bit 10 in both views
	//////////////////////////////////////////////////////////////

	typedef struct packed {
		logic               tail;  // end of packet marker
		logic [ROUTE_W-1:0] route; // destination, ignored once it reaches us
	} header_flit_t;

	typedef struct packed {
		logic                      tail;    // set on the last data flit of a packet
		logic [FLIT_PAYLOAD_W-1:0] payload; // one ten bit slice of a core word
	} data_flit_t;

	// same 11 bit word, decoded by position in the packet
	typedef union packed {
		header_flit_t hdr;
		data_flit_t   data;
	} flit_t;

	//////////////////////////////////////////////////////////////
	// core side formats
	//////////////////////////////////////////////////////////////

	// [ code | data ], top PAD_W code bits always zero
	typedef struct packed {
		logic [CODE_W-1:0] code;
		logic [DATA_W-1:0] data;
	} core_word_t;

	// outbound request, one word per packet
	typedef struct packed {
		logic [ROUTE_W-1:0] route; // goes into the header flit
		core_word_t         word;  // split over three data flits
	} core_tx_t;

endpackage

//--- logic/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo #(
	parameter int FIFO_DEPTH = 8 // entries, also the sender's starting credit
) (
	input  logic          clk,
	input  logic          reset,
	input  ni_pkg::flit_t wr_flit, // flit from the router
	input  logic          wr_en,   // router sends only with credit
	input  logic          rdreq,   // consumer takes the head
	output ni_pkg::flit_t rd_flit, // head of queue
	output logic          empty,
	output logic          credit   // one pulse per pop, back to the router
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	ni_pkg::flit_t mem [FIFO_DEPTH]; // flit storage, no reset needed

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // entries held
	logic             full;
	logic             push;
	logic             pop;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(FIFO_DEPTH));

	assign push = wr_en && !full; // full never seen while credits are honoured
	assign pop  = rdreq && !empty;

	assign rd_flit = mem[rd_ptr]; // head visible the cycle after its write
	assign credit  = pop;         // a freed slot is a credit

	//////////////////////////////////////////////////////////////
	// storage write
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_flit;
		end
	end

	//////////////////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				// explicit wrap, depth need not be a power of two
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle, or push and pop together
			endcase
		end
	end

endmodule

//--- ni/flit_deserializer.sv
`timescale 1ns/1ps

module flit_deserializer (
	input  logic               clk,
	input  logic               reset,
	input  ni_pkg::flit_t      flit,     // fifo head
	input  logic               empty,    // fifo has nothing for us
	input  logic               rx_ack,   // core took the word
	output logic               rdreq,    // pop the head
	output ni_pkg::core_word_t rx_word,  // assembled word to the core
	output logic               rx_valid
);

	//////////////////////////////////////////////////////////////
	// state encoding
	//
	//   wait_hdr  -> data0 -> data1 -> data2 -> hold_hdr  -> wait_hdr
	//                  ^                      \-> hold_data -> data0
	//
	// the tail bit of the third data flit picks the hold state
	//////////////////////////////////////////////////////////////

	localparam logic [2:0] S_WAIT_HDR  = 3'd0; // next flit is a header, drop it
	localparam logic [2:0] S_DATA0     = 3'd1; // payload for word bits 29..20
	localparam logic [2:0] S_DATA1     = 3'd2; // payload for bits 19..10
	localparam logic [2:0] S_DATA2     = 3'd3; // payload for bits 9..0, tail sampled
	localparam logic [2:0] S_HOLD_HDR  = 3'd4; // word out, packet done
	localparam logic [2:0] S_HOLD_DATA = 3'd5; // word out, same packet continues

	localparam int PW = ni_pkg::FLIT_PAYLOAD_W;

	logic [2:0] state;
	logic [2:0] next_state;

	logic [ni_pkg::CARRIED_W-1:0] word_q; // the thirty bits that travel
	logic                         take;   // head is popped this cycle
	logic                         holding;

	assign holding = (state == S_HOLD_HDR) || (state == S_HOLD_DATA);

	// pop whenever a flit sits at the head and we are not holding a word
	assign rdreq = !holding && !empty;
	assign take  = rdreq;

	// valid straight from the registered state, so it rises the edge after data2
	assign rx_valid = holding;

	// pad the code msbs back in
	assign rx_word = ni_pkg::core_word_t'({{ni_pkg::PAD_W{1'b0}}, word_q});

	//////////////////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			S_WAIT_HDR: begin
				if (take) next_state = S_DATA0; // header payload discarded
			end
			S_DATA0: begin
				if (take) next_state = S_DATA1;
			end
			S_DATA1: begin
				if (take) next_state = S_DATA2;
			end
			S_DATA2: begin
				if (take) begin
					next_state = flit.data.tail ? S_HOLD_HDR : S_HOLD_DATA;
				end
			end
			S_HOLD_HDR: begin
				if (rx_ack) next_state = S_WAIT_HDR;
			end
			S_HOLD_DATA: begin
				if (rx_ack) next_state = S_DATA0; // more words, no header between
			end
			default: next_state = S_WAIT_HDR; // unused codes fall back to a header hunt
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_WAIT_HDR;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////////////////
	// word assembly
	//////////////////////////////////////////////////////////////

	// only written in data states, so the word is frozen while rx_valid is up
	always_ff @(posedge clk) begin
		if (take) begin
			case (state)
				S_DATA0: word_q[2*PW +: PW] <= flit.data.payload; // msb slice
				S_DATA1: word_q[PW +: PW]   <= flit.data.payload;
				S_DATA2: word_q[0 +: PW]    <= flit.data.payload; // lsb slice
				default: word_q             <= word_q; // header flit, nothing kept
			endcase
		end
	end

endmodule

//--- ni/flit_serializer.sv
`timescale 1ns/1ps

module flit_serializer #(
	parameter int OUT_CREDITS = 4 // downstream buffer slots
) (
	input  logic             clk,
	input  logic             reset,
	input  ni_pkg::core_tx_t tx_req,        // route plus word from the core
	input  logic             tx_valid,
	input  logic             out_credit,    // one slot freed downstream
	output logic             tx_ack,        // request taken this cycle
	output ni_pkg::flit_t    out_flit,
	output logic             out_flit_valid
);

	localparam int CRED_W = $clog2(OUT_CREDITS + 1);
	localparam int PW     = ni_pkg::FLIT_PAYLOAD_W;

	ni_pkg::core_tx_t req_q; // latched request, payload only

	logic [ni_pkg::WORD_W-1:0] word_bits; // word as a flat vector for slicing
	logic [1:0]                flit_idx;  // 0 header, 1..3 data
	logic                      busy;      // packet in progress
	logic [CRED_W-1:0]         credits;   // free slots downstream
	logic                      send;

	assign tx_ack    = tx_valid && !busy; // accept only between packets
	assign word_bits = req_q.word;

	// hold the current flit while out of credit
	assign out_flit_valid = busy && (credits != '0);
	assign send           = out_flit_valid;

	//////////////////////////////////////////////////////////////
	// flit build
	//////////////////////////////////////////////////////////////

	always_comb begin
		out_flit = '0;
		case (flit_idx)
			2'd0: begin
				out_flit.hdr.route = req_q.route; // header, tail clear
				out_flit.hdr.tail  = 1'b0;
			end
			2'd1: begin
				out_flit.data.payload = word_bits[2*PW +: PW]; // bits 29..20
				out_flit.data.tail    = 1'b0;
			end
			2'd2: begin
				out_flit.data.payload = word_bits[PW +: PW];
				out_flit.data.tail    = 1'b0;
			end
			default: begin
				out_flit.data.payload = word_bits[0 +: PW]; // last slice
				out_flit.data.tail    = 1'b1;               // closes the packet
			end
		endcase
	end

	//////////////////////////////////////////////////////////////
	// request latch and sequencing
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (tx_ack) begin
			req_q <= tx_req;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy     <= 1'b0;
			flit_idx <= 2'd0;
		end else if (tx_ack) begin
			busy     <= 1'b1; // header goes out next cycle if credit allows
			flit_idx <= 2'd0;
		end else if (send) begin
			flit_idx <= flit_idx + 1'b1; // wraps back to 0 after the tail
			if (flit_idx == 2'd3) begin
				busy <= 1'b0; // tail left, free for the next request
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// credit counter
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			credits <= CRED_W'(OUT_CREDITS); // downstream starts empty
		end else begin
			case ({out_credit, send})
				2'b10:   credits <= credits + 1'b1; // slot returned
				2'b01:   credits <= credits - 1'b1; // slot used
				default: credits <= credits;        // both or neither
			endcase
		end
	end

endmodule

//--- ni/network_interface.sv
`timescale 1ns/1ps

module network_interface #(
	parameter int FIFO_DEPTH  = 8, // inbound fifo slots, router starts with this credit
	parameter int OUT_CREDITS = 4  // slots in the downstream router buffer
) (
	input  logic               clk,
	input  logic               reset,
	// inbound link
	input  ni_pkg::flit_t      in_flit,
	input  logic               in_flit_valid,
	output logic               in_credit,
	// core receive channel
	output ni_pkg::core_word_t rx_word,
	output logic               rx_valid,
	input  logic               rx_ack,
	// core transmit channel
	input  ni_pkg::core_tx_t   tx_req,
	input  logic               tx_valid,
	output logic               tx_ack,
	// outbound link
	output ni_pkg::flit_t      out_flit,
	output logic               out_flit_valid,
	input  logic               out_credit
);

	ni_pkg::flit_t fifo_flit;  // head flit into the deserializer
	logic          fifo_empty;
	logic          fifo_rdreq;

	//////////////////////////////////////////////////////////////
	// inbound, router -> fifo -> deserializer -> core
	//////////////////////////////////////////////////////////////

	flit_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_flit_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr_flit (in_flit),
		.wr_en   (in_flit_valid),
		.rdreq   (fifo_rdreq),
		.rd_flit (fifo_flit),
		.empty   (fifo_empty),
		.credit  (in_credit)  // pop pulse goes straight back upstream
	);

	flit_deserializer u_flit_deserializer (
		.clk      (clk),
		.reset    (reset),
		.flit     (fifo_flit),
		.empty    (fifo_empty),
		.rx_ack   (rx_ack),
		.rdreq    (fifo_rdreq),
		.rx_word  (rx_word),
		.rx_valid (rx_valid)
	);

	//////////////////////////////////////////////////////////////
	// outbound, core -> serializer -> router
	//////////////////////////////////////////////////////////////

	flit_serializer #(
		.OUT_CREDITS (OUT_CREDITS)
	) u_flit_serializer (
		.clk            (clk),
		.reset          (reset),
		.tx_req         (tx_req),
		.tx_valid       (tx_valid),
		.out_credit     (out_credit),
		.tx_ack         (tx_ack),
		.out_flit       (out_flit),
		.out_flit_valid (out_flit_valid)
	);

endmodule

//--- test/ni_props.sv
`timescale 1ns/1ps

module ni_props #(
	parameter int FIFO_DEPTH  = 8,
	parameter int OUT_CREDITS = 4
) (
	input logic               clk,
	input logic               reset,
	input logic               in_flit_valid,
	input logic               fifo_rdreq,  // deserializer wants the head
	input logic               fifo_empty,  // fifo holds nothing
	input ni_pkg::core_word_t rx_word,
	input logic               rx_valid,
	input logic               rx_ack,
	input logic               out_flit_valid,
	input logic               out_credit
);

	int fifo_fill;    // pushes on the link minus real pops inside
	int link_credits; // what the serializer should still hold

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fifo_fill    <= 0;
			link_credits <= OUT_CREDITS;
		end else begin
			fifo_fill    <= fifo_fill + int'(in_flit_valid) - int'(fifo_rdreq && !fifo_empty);
			link_credits <= link_credits + int'(out_credit) - int'(out_flit_valid);
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		in_flit_valid |-> fifo_fill < FIFO_DEPTH)
		else $error("flit arrived with the inbound fifo full");

	// word frozen until the core takes it
	a_rx_stable: assert property (@(posedge clk) disable iff (reset)
		rx_valid && !rx_ack |=> rx_valid && $stable(rx_word))
		else $error("rx_word changed or rx_valid dropped before the ack");

	a_out_credit: assert property (@(posedge clk) disable iff (reset)
		out_flit_valid |-> link_credits > 0)
		else $error("outbound flit sent with no credit left");

endmodule

bind network_interface ni_props #(
	.FIFO_DEPTH  (FIFO_DEPTH),
	.OUT_CREDITS (OUT_CREDITS)
) u_ni_props (
	.clk            (clk),
	.reset          (reset),
	.in_flit_valid  (in_flit_valid),
	.fifo_rdreq     (fifo_rdreq),
	.fifo_empty     (fifo_empty),
	.rx_word        (rx_word),
	.rx_valid       (rx_valid),
	.rx_ack         (rx_ack),
	.out_flit_valid (out_flit_valid),
	.out_credit     (out_credit)
);

//--- test/tb_network_interface.sv
`timescale 1ns/1ps

module tb_network_interface;

	localparam int CLK_PERIOD  = 8;
	localparam int FIFO_DEPTH  = 8;
	localparam int OUT_CREDITS = 4;
	localparam logic [31:0] SEED = 32'h88ebf135;
	localparam logic [31:0] TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

	localparam int T2_PKTS = 12; // single word packets
	localparam int T3_PKTS = 8;  // multi word packets, 1..4 words
	localparam int T4_PKTS = 10; // slow core
	localparam int T5_REQS = 12; // outbound only
	localparam int T6_PKTS = 10; // both directions at once
	// worst case cycles per test, holds up to 63 and credit delays up to 16
	localparam int STIM_CYCLES = 20 + T2_PKTS * 4 * 2 + T3_PKTS * 13 * 2 + T4_PKTS * 13 * 64
		+ T5_REQS * 4 * 2 + T6_PKTS * 4 * 16 * 2;
	localparam int WATCHDOG_CYCLES = 4 * STIM_CYCLES;

	logic               clk           = 1'b0;
	logic               reset         = 1'b1;
	ni_pkg::flit_t      in_flit       = '0;
	logic               in_flit_valid = 1'b0;
	logic               in_credit;
	ni_pkg::core_word_t rx_word;
	logic               rx_valid;
	logic               rx_ack        = 1'b0;
	ni_pkg::core_tx_t   tx_req        = '0;
	logic               tx_valid      = 1'b0;
	logic               tx_ack;
	ni_pkg::flit_t      out_flit;
	logic               out_flit_valid;
	logic               out_credit    = 1'b0;

	ni_pkg::flit_t    in_q[$];      // flits the router model still has to send
	logic [31:0]      exp_rx_q[$];  // words the core should see, in order
	ni_pkg::core_tx_t tx_q[$];      // requests not yet offered
	logic [10:0]      exp_out_q[$]; // flits the outbound link should carry
	int               ds_due[$];    // cycles at which downstream frees a slot

	int errors = 0;
	int checks = 0;
	int tests  = 0;
	int test_err0 = 0;
	int test_chk0 = 0;
	int credit_pulses  = 0;
	int router_credits = 0;
	int inflight = 0; // outbound flits not yet credited back
	int cycle    = 0;
	int last_due = 0;
	int hold_cnt = 0;
	int ack_bits = 0; // width of random ack hold, 0 acks at once
	int ds_bits  = 0; // width of random credit delay
	logic gaps_en    = 1'b0;
	logic idle_check = 1'b0;

	// one lfsr state per process so each stream stays reproducible
	logic [31:0] gen_st  = SEED;
	logic [31:0] core_st = SEED;
	logic [31:0] rtr_st  = SEED;
	logic [31:0] ds_st   = SEED;

	network_interface #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) UUT (
		.clk            (clk),
		.reset          (reset),
		.in_flit        (in_flit),
		.in_flit_valid  (in_flit_valid),
		.in_credit      (in_credit),
		.rx_word        (rx_word),
		.rx_valid       (rx_valid),
		.rx_ack         (rx_ack),
		.tx_req         (tx_req),
		.tx_valid       (tx_valid),
		.tx_ack         (tx_ack),
		.out_flit       (out_flit),
		.out_flit_valid (out_flit_valid),
		.out_credit     (out_credit)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1); // galois, shift right
	endfunction

	task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_step(st);
			v  = {v[30:0], st[0]}; // one step per bit
		end
	endtask

	// three payloads, first one on top, two pad bits above
	function automatic logic [31:0] pack_word(input logic [9:0] p0, input logic [9:0] p1,
		input logic [9:0] p2);
		return {2'b00, p0, p1, p2};
	endfunction

	// header in the top 11 bits, then data flits, tail only on the last
	function automatic logic [43:0] build_flits(input logic [9:0] route, input logic [31:0] w);
		return {1'b0, route, 1'b0, w[29:20], 1'b0, w[19:10], 1'b1, w[9:0]};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus builders
	////////////////////////////////////////////////////////////

	task automatic queue_packet(input int n_words);
		ni_pkg::flit_t f;
		logic [31:0]   r;
		logic [9:0]    p [3];
		take_bits(gen_st, 10, r);
		f.hdr.tail  = 1'b0;
		f.hdr.route = r[9:0]; // random route, must never reach the word
		in_q.push_back(f);
		for (int w = 0; w < n_words; w++) begin
			for (int i = 0; i < 3; i++) begin
				take_bits(gen_st, 10, r);
				p[i]           = r[9:0];
				f.data.payload = p[i];
				f.data.tail    = (w == n_words - 1) && (i == 2); // last triple only
				in_q.push_back(f);
			end
			exp_rx_q.push_back(pack_word(p[0], p[1], p[2]));
		end
	endtask

	task automatic queue_request();
		ni_pkg::core_tx_t t;
		logic [31:0]      r;
		logic [43:0]      flits;
		take_bits(gen_st, 10, r);
		t.route = r[9:0];
		take_bits(gen_st, 30, r);
		t.word = {2'b00, r[29:0]}; // code msbs zero on input
		tx_q.push_back(t);
		flits = build_flits(t.route, t.word);
		for (int i = 3; i >= 0; i--) begin
			exp_out_q.push_back(flits[i*11 +: 11]);
		end
	endtask

	function automatic bit traffic_pending();
		return in_q.size() != 0 || exp_rx_q.size() != 0 || tx_q.size() != 0
			|| exp_out_q.size() != 0 || tx_valid || ds_due.size() != 0;
	endfunction

	task automatic wait_idle();
		@(posedge clk);
		while (traffic_pending()) @(posedge clk);
		repeat (2) @(posedge clk); // let the last credit land
	endtask

	task automatic begin_test();
		test_err0 = errors;
		test_chk0 = checks;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d checks, %0d errors", tests, name,
			checks - test_chk0, errors - test_err0);
	endtask

	////////////////////////////////////////////////////////////
	// link and core models
	////////////////////////////////////////////////////////////

	// router side, sends only while holding credit
	always @(posedge clk) begin
		logic [31:0] r;
		if (reset) begin
			router_credits = FIFO_DEPTH; // one per fifo slot
			in_flit_valid <= 1'b0;
		end else begin
			if (in_credit) begin
				router_credits++;
				credit_pulses++;
			end
			r = '0;
			if (gaps_en) take_bits(rtr_st, 1, r); // idle cycle half the time
			if (router_credits > 0 && in_q.size() > 0 && r == '0) begin
				in_flit       <= in_q.pop_front();
				in_flit_valid <= 1'b1;
				router_credits--;
			end else begin
				in_flit_valid <= 1'b0;
			end
		end
	end

	// core receive side, random hold after every word taken
	always @(posedge clk) begin
		logic [31:0] r;
		if (reset) begin
			rx_ack  <= 1'b0;
			hold_cnt = 0;
		end else if (rx_valid && rx_ack) begin
			take_bits(core_st, ack_bits, r);
			hold_cnt = r;
			rx_ack <= (r == '0);
		end else if (hold_cnt > 0) begin
			hold_cnt--;
			rx_ack <= 1'b0;
		end else begin
			rx_ack <= 1'b1;
		end
	end

	// core transmit side
	always @(posedge clk) begin
		if (reset) begin
			tx_valid <= 1'b0;
		end else if (!tx_valid || tx_ack) begin
			if (tx_q.size() > 0) begin
				tx_req   <= tx_q.pop_front();
				tx_valid <= 1'b1;
			end else begin
				tx_valid <= 1'b0;
			end
		end
	end

	// downstream buffer, credits come back in order after a random delay
	always @(posedge clk) begin
		logic [31:0] d;
		if (reset) begin
			out_credit <= 1'b0;
			inflight = 0;
			cycle    = 0;
			last_due = 0;
		end else begin
			cycle++;
			if (out_credit) inflight--;
			if (out_flit_valid) begin
				inflight++;
				take_bits(ds_st, ds_bits, d);
				last_due = (cycle + 1 + int'(d) > last_due + 1) ?
					cycle + 1 + int'(d) : last_due + 1;
				ds_due.push_back(last_due);
				check("flits_in_flight_ok", 32'(inflight <= OUT_CREDITS), 1);
			end
			if (ds_due.size() > 0 && ds_due[0] <= cycle) begin
				out_credit <= 1'b1;
				void'(ds_due.pop_front());
			end else begin
				out_credit <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!reset) begin
			if (idle_check) begin // nothing sent yet, all quiet
				check("rx_valid", 32'(rx_valid), 0);
				check("tx_ack", 32'(tx_ack), 0);
				check("out_flit_valid", 32'(out_flit_valid), 0);
				check("in_credit", 32'(in_credit), 0);
			end
			if (rx_valid && rx_ack) begin
				if (exp_rx_q.size() == 0) begin
					errors++;
					$display("ERROR at %0t: core received a word that no packet accounts for",
						$time);
				end else begin
					check("rx_word", 32'(rx_word), exp_rx_q.pop_front());
				end
				check("rx_word_pad", 32'(rx_word.code[7:6]), 0);
			end
			if (out_flit_valid) begin
				if (exp_out_q.size() == 0) begin
					errors++;
					$display("ERROR at %0t: outbound flit sent with no request behind it",
						$time);
				end else begin
					check("out_flit", 32'(out_flit), 32'(exp_out_q.pop_front()));
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		int          n_flits;
		int          pulses0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		begin_test();
		idle_check <= 1'b1;
		repeat (10) @(posedge clk);
		idle_check <= 1'b0;
		@(posedge clk);
		check("in_credit_pulses", credit_pulses, 0); // no pop, no credit
		end_test("reset and idle");

		begin_test();
		for (int i = 0; i < T2_PKTS; i++) queue_packet(1);
		wait_idle();
		end_test("single word packets");

		begin_test();
		for (int i = 0; i < T3_PKTS; i++) begin
			take_bits(gen_st, 2, r);
			queue_packet(1 + int'(r));
		end
		queue_packet(1); // decodes only if the header was found again
		wait_idle();
		end_test("multi word packets");

		begin_test();
		ack_bits <= 6; // holds of up to 63 cycles, fifo fills
		pulses0 = credit_pulses;
		n_flits = 0;
		for (int i = 0; i < T4_PKTS; i++) begin
			take_bits(gen_st, 2, r);
			queue_packet(1 + int'(r));
			n_flits += 1 + 3 * (1 + int'(r));
		end
		wait_idle();
		check("in_credit_pulses", credit_pulses - pulses0, n_flits);
		check("router_credits", router_credits, FIFO_DEPTH);
		end_test("slow core back pressure");

		begin_test();
		ack_bits <= 0;
		for (int i = 0; i < T5_REQS; i++) queue_request();
		wait_idle();
		end_test("outbound requests");

		begin_test();
		ack_bits <= 3;
		ds_bits  <= 4; // credit back after 1..16 cycles
		gaps_en  <= 1'b1;
		for (int i = 0; i < T6_PKTS; i++) begin
			take_bits(gen_st, 2, r);
			queue_packet(1 + int'(r));
			queue_request();
		end
		wait_idle();
		end_test("both directions, slow credits");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, traffic never drained", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- network_interface.f
common/ni_pkg.sv
logic/flit_fifo.sv
ni/flit_deserializer.sv
ni/flit_serializer.sv
ni/network_interface.sv
test/ni_props.sv
test/tb_network_interface.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and decide by the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_network_interface \
	-f network_interface.f -o tb_network_interface > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_network_interface > sim.log 2>&1
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }
